/* Makefile */
BIN := obj_dir/Vsha256_tb

.PHONY: run clean

run: $(BIN)
	$(BIN) > sim.log 2>&1; cat sim.log
	grep -q '^TEST PASS$$' sim.log

$(BIN): vlog.f $(wildcard src/*.sv bench/*.sv bench/*.svh)
	verilator --binary --timing --assert --top-module sha256_tb -f vlog.f

clean:
	rm -rf obj_dir sim.log

/* bench/sha256_ref_model.svh */
// Reference SHA-256 and LFSR
`ifndef SHA256_REF_MODEL_SVH
`define SHA256_REF_MODEL_SVH

localparam logic [31:0] LFSR_TAPS = 32'h80200003;

// Galois form, output bit is bit 0
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
	logic [31:0] nxt;
	nxt = state >> 1;
	if (state[0]) begin
		nxt = nxt ^ LFSR_TAPS;
	end
	return nxt;
endfunction

// Digest of one 256-bit message padded to a single block
function automatic msg_block_t ref_digest(input msg_block_t msg);
	word_t      w [64];
	word_t      a;
	word_t      b;
	word_t      c;
	word_t      d;
	word_t      e;
	word_t      f;
	word_t      g;
	word_t      h;
	word_t      t1;
	word_t      t2;
	msg_block_t hash;
	for (int i = 0; i < 8; i++) begin
		w[i] = msg[i];
	end
	// End marker, zeros, then the length in bits
	w[8] = 32'h80000000;
	for (int i = 9; i < 15; i++) begin
		w[i] = '0;
	end
	w[15] = 32'd256;
	for (int i = 16; i < 64; i++) begin
		w[i] = ssig1(w[i - 2]) + w[i - 7] + ssig0(w[i - 15]) + w[i - 16];
	end
	a = H_INIT.a;
	b = H_INIT.b;
	c = H_INIT.c;
	d = H_INIT.d;
	e = H_INIT.e;
	f = H_INIT.f;
	g = H_INIT.g;
	h = H_INIT.h;
	for (int i = 0; i < 64; i++) begin
		t1 = h + bsig1(e) + ch_f(e, f, g) + ROUND_K[i] + w[i];
		t2 = bsig0(a) + maj_f(a, b, c);
		h = g;
		g = f;
		f = e;
		e = d + t1;
		d = c;
		c = b;
		b = a;
		a = t1 + t2;
	end
	hash[0] = a + H_INIT.a;
	hash[1] = b + H_INIT.b;
	hash[2] = c + H_INIT.c;
	hash[3] = d + H_INIT.d;
	hash[4] = e + H_INIT.e;
	hash[5] = f + H_INIT.f;
	hash[6] = g + H_INIT.g;
	hash[7] = h + H_INIT.h;
	return hash;
endfunction

`endif

/* bench/sha256_tb.sv */
// SHA-256 block hasher testbench
`timescale 1ns/1ps

module sha256_tb import sha256_pkg::*; ();

	`include "sha256_ref_model.svh"

	localparam int FILL_STROBES = 65;
	localparam int FILL_LIMIT   = 1000;

	// SHA-256 of "abc"
	localparam msg_block_t ABC_BLOCK = {
		32'hba7816bf, 32'h8f01cfea, 32'h414140de, 32'h5dae2223,
		32'hb00361a3, 32'h96177a9c, 32'hb410ff61, 32'hf20015ad
	};

	typedef struct packed {
		int         entry;
		msg_block_t digest;
	} exp_entry_t;

	logic        CLK;
	logic        por_rst;
	logic        ext_rst;
	logic        RST;
	logic        advance;
	msg_block_t  block;
	msg_block_t  digest;
	logic        valid;

	int          strobe_cnt;
	logic        armed;
	logic        timed_out;
	logic        exp_valid;
	msg_block_t  exp_digest;
	exp_entry_t  exp_q [$];
	logic [31:0] lfsr_state;
	int          value_errors;
	int          other_errors;

	assign RST = por_rst & ext_rst;

	tb_clock i_clk (
		.CLK (CLK),
		.RST (por_rst)
	);

	sha256_block_hasher i_dut (
		.CLK       (CLK),
		.RST       (RST),
		.advance_i (advance),
		.block_i   (block),
		.digest_o  (digest),
		.valid_o   (valid)
	);

	valid_matches: assert property (@(posedge CLK) armed |-> valid == exp_valid)
	else begin
		value_errors++;
		$display("** Error at %0t: valid_o expected %b got %b", $time,
			$sampled(exp_valid), $sampled(valid));
	end

	digest_matches: assert property (@(posedge CLK) armed |-> digest == exp_digest)
	else begin
		value_errors++;
		$display("** Error at %0t: digest_o expected %h got %h", $time,
			$sampled(exp_digest), $sampled(digest));
	end

	zero_while_invalid: assert property (@(posedge CLK) armed && !valid |-> digest == '0)
	else begin
		value_errors++;
		$display("** Error at %0t: digest_o expected 0 got %h", $time, $sampled(digest));
	end

	// Stalled clocks freeze the outputs
	hold_digest: assert property (@(posedge CLK) disable iff (!RST)
		armed && !advance |=> $stable(digest))
	else begin
		value_errors++;
		$display("** Error at %0t: digest_o expected %h got %h", $time,
			$past(digest), $sampled(digest));
	end

	hold_valid: assert property (@(posedge CLK) disable iff (!RST)
		armed && !advance |=> $stable(valid))
	else begin
		value_errors++;
		$display("** Error at %0t: valid_o expected %b got %b", $time,
			$past(valid), $sampled(valid));
	end

	valid_sticky: assert property (@(posedge CLK) disable iff (!RST)
		armed && valid |=> valid)
	else begin
		value_errors++;
		$display("** Error at %0t: valid_o expected 1 got 0", $time);
	end

	valid_rise_strobe: assert property (@(posedge CLK)
		armed && $rose(valid) |-> strobe_cnt == FILL_STROBES + 1)
	else begin
		value_errors++;
		$display("** Error at %0t: strobe count at valid_o rise expected %0d got %0d",
			$time, FILL_STROBES + 1, $sampled(strobe_cnt));
	end

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			val = {val[30:0], lfsr_state[0]};
		end
		return val;
	endfunction

	function automatic msg_block_t random_block();
		msg_block_t blk;
		for (int i = 0; i < 8; i++) begin
			blk[i] = take_bits(32);
		end
		return blk;
	endfunction

	function automatic void clear_expect();
		strobe_cnt = 0;
		exp_q.delete();
		exp_valid  = 1'b0;
		exp_digest = '0;
	endfunction

	// Bookkeeping for the rising edge just past
	function automatic void account_edge();
		exp_entry_t pushed;
		exp_entry_t popped;
		if (RST !== 1'b1) begin
			clear_expect();
		end else if (advance) begin
			strobe_cnt++;
			pushed.entry  = strobe_cnt;
			pushed.digest = ref_digest(block);
			exp_q.push_back(pushed);
			// A block leaves the pipeline 65 strobes after it entered
			if (exp_q[0].entry + FILL_STROBES == strobe_cnt) begin
				popped     = exp_q.pop_front();
				exp_valid  = 1'b1;
				exp_digest = popped.digest;
			end
		end
	endfunction

	task automatic step(input logic adv, input msg_block_t blk);
		@(negedge CLK);
		account_edge();
		armed   = 1'b1;
		advance = adv;
		block   = blk;
	endtask

	task automatic wait_reset_release();
		int n;
		n = 0;
		while (RST !== 1'b1 && n < 40) begin
			step(1'b0, '0);
			n++;
		end
		if (RST !== 1'b1) begin
			timed_out = 1'b1;
			other_errors++;
			$display("Timeout: reset was not released within 40 cycles");
		end
	endtask

	task automatic fill_until_valid(input logic with_stalls);
		int n;
		n = 0;
		while (valid !== 1'b1 && n < FILL_LIMIT) begin
			if (with_stalls && take_bits(2) == 0) begin
				step(1'b0, random_block());
			end else begin
				step(1'b1, random_block());
			end
			n++;
		end
		if (valid !== 1'b1) begin
			timed_out = 1'b1;
			other_errors++;
			$display("Timeout: valid_o did not rise within %0d cycles", FILL_LIMIT);
		end
	endtask

	task automatic run_stream(input int count);
		repeat (count) step(1'b1, random_block());
	endtask

	task automatic run_with_stalls(input int count);
		int gap;
		for (int i = 0; i < count; i++) begin
			if (take_bits(2) == 0) begin
				gap = int'(take_bits(3)) + 1;
				repeat (gap) step(1'b0, random_block());
			end
			step(1'b1, random_block());
		end
	endtask

	// Reset lands on a full pipeline while inputs keep moving
	task automatic apply_reset(input int cycles);
		@(negedge CLK);
		account_edge();
		ext_rst = 1'b0;
		clear_expect();
		advance = 1'b1;
		block   = random_block();
		repeat (cycles) step(1'b1, random_block());
		@(negedge CLK);
		account_edge();
		ext_rst = 1'b1;
		advance = 1'b0;
	endtask

	task automatic finish_run();
		$display("Errors: %0d value, %0d other", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	endtask

	initial begin
		advance      = 1'b0;
		block        = '0;
		ext_rst      = 1'b1;
		armed        = 1'b0;
		timed_out    = 1'b0;
		lfsr_state   = 32'd15;
		value_errors = 0;
		other_errors = 0;
		clear_expect();

		wait_reset_release();
		// Known message first so its digest comes out with the first valid
		if (!timed_out) begin
			step(1'b1, ABC_BLOCK);
			fill_until_valid(1'b0);
		end
		if (!timed_out) begin
			run_stream(120);
			run_with_stalls(150);
			apply_reset(3);
			fill_until_valid(1'b1);
		end
		if (!timed_out) begin
			run_with_stalls(60);
			run_stream(80);
			repeat (3) step(1'b0, '0);
		end
		finish_run();
	end

endmodule

/* bench/tb_clock.sv */
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clock (
	output logic CLK,
	output logic RST
);

	initial begin
		CLK = 1'b0;
		RST = 1'b0;
		// Held for 10 cycles, released on a falling edge
		repeat (10) @(posedge CLK);
		@(negedge CLK);
		RST = 1'b1;
	end

	always #5 CLK = ~CLK;

endmodule

/* src/sha256_block_hasher.sv */
// SHA-256 single block hasher
`timescale 1ns/1ps

module sha256_block_hasher import sha256_pkg::*; (
	input  logic       CLK,
	input  logic       RST,
	input  logic       advance_i,
	input  msg_block_t block_i,
	output msg_block_t digest_o,
	output logic       valid_o
);

	sha_state_t final_state;

	sha256_round_pipe i_pipe (
		.CLK       (CLK),
		.RST       (RST),
		.advance_i (advance_i),
		.block_i   (block_i),
		.state_o   (final_state)
	);

	sha256_digest_out i_out (
		.CLK       (CLK),
		.RST       (RST),
		.advance_i (advance_i),
		.state_i   (final_state),
		.digest_o  (digest_o),
		.valid_o   (valid_o)
	);

endmodule

/* src/sha256_comp_round.sv */
// SHA-256 compression round
`timescale 1ns/1ps

module sha256_comp_round import sha256_pkg::*; (
	input  logic       CLK,
	input  logic       RST,
	input  logic       advance_i,
	input  word_t      k_i,
	input  word_t      w_i,
	input  sha_state_t state_i,
	output sha_state_t state_o
);

	sha_state_t state_q;
	word_t      temp1;
	word_t      temp2;

	assign temp1 = state_i.h + bsig1(state_i.e) + ch_f(state_i.e, state_i.f, state_i.g)
		+ k_i + w_i;
	assign temp2 = bsig0(state_i.a) + maj_f(state_i.a, state_i.b, state_i.c);

	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			state_q <= '0;
		end else if (advance_i) begin
			state_q.a <= temp1 + temp2;
			state_q.b <= state_i.a;
			state_q.c <= state_i.b;
			state_q.d <= state_i.c;
			// d picks up temp1 on its way into e
			state_q.e <= state_i.d + temp1;
			state_q.f <= state_i.e;
			state_q.g <= state_i.f;
			state_q.h <= state_i.g;
		end
	end

	assign state_o = state_q;

endmodule

/* src/sha256_digest_out.sv */
// SHA-256 digest output stage
`timescale 1ns/1ps

module sha256_digest_out import sha256_pkg::*; (
	input  logic       CLK,
	input  logic       RST,
	input  logic       advance_i,
	input  sha_state_t state_i,
	output msg_block_t digest_o,
	output logic       valid_o
);

	// Strobes until the first block has left round 63
	localparam logic [6:0] FILL_DEPTH = 7'(NUM_ROUNDS + 1);

	// Working variables a..h map onto words 0..7
	localparam msg_block_t INIT_WORDS = msg_block_t'(H_INIT);

	logic [6:0] fill_cnt;
	msg_block_t final_words;
	msg_block_t digest_sum;

	assign final_words = msg_block_t'(state_i);

	always_comb begin
		for (int i = 0; i < 8; i++) begin
			digest_sum[i] = final_words[i] + INIT_WORDS[i];
		end
	end

	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			fill_cnt <= '0;
			valid_o  <= 1'b0;
			digest_o <= '0;
		end else if (advance_i) begin
			if (fill_cnt == FILL_DEPTH) begin
				valid_o  <= 1'b1;
				digest_o <= digest_sum;
			end else begin
				// Round 63 holds no real block yet
				fill_cnt <= fill_cnt + 7'd1;
				valid_o  <= 1'b0;
				digest_o <= '0;
			end
		end
	end

endmodule

/* src/sha256_pkg.sv */
// SHA-256 shared definitions
package sha256_pkg;

	localparam int NUM_ROUNDS = 64;

	typedef logic [31:0] word_t;

	// Working variables a..h, a in the top bits
	typedef struct packed {
		word_t a;
		word_t b;
		word_t c;
		word_t d;
		word_t e;
		word_t f;
		word_t g;
		word_t h;
	} sha_state_t;

	// Index 0 is the oldest word and sits in the top bits
	typedef word_t [0:15] sched_win_t;

	typedef word_t [0:7] msg_block_t;

	localparam word_t ROUND_K [NUM_ROUNDS] = '{
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	localparam sha_state_t H_INIT = '{
		a: 32'h6a09e667,
		b: 32'hbb67ae85,
		c: 32'h3c6ef372,
		d: 32'ha54ff53a,
		e: 32'h510e527f,
		f: 32'h9b05688c,
		g: 32'h1f83d9ab,
		h: 32'h5be0cd19
	};

	// Words 8..15 of the block: end marker, zeros, bit length 256
	localparam msg_block_t PAD_WORDS = {
		32'h80000000,
		32'h00000000,
		32'h00000000,
		32'h00000000,
		32'h00000000,
		32'h00000000,
		32'h00000000,
		32'h00000100
	};

	function automatic word_t rotr(word_t x, int unsigned n);
		return (x >> n) | (x << (32 - n));
	endfunction

	// Compression sigmas
	function automatic word_t bsig0(word_t x);
		return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
	endfunction

	function automatic word_t bsig1(word_t x);
		return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
	endfunction

	// Schedule sigmas
	function automatic word_t ssig0(word_t x);
		return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
	endfunction

	function automatic word_t ssig1(word_t x);
		return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
	endfunction

	function automatic word_t ch_f(word_t x, word_t y, word_t z);
		return (x & y) ^ (~x & z);
	endfunction

	function automatic word_t maj_f(word_t x, word_t y, word_t z);
		return (x & y) ^ (x & z) ^ (y & z);
	endfunction

endpackage

/* src/sha256_round_pipe.sv */
// Unrolled SHA-256 round pipeline
`timescale 1ns/1ps

module sha256_round_pipe import sha256_pkg::*; (
	input  logic       CLK,
	input  logic       RST,
	input  logic       advance_i,
	input  msg_block_t block_i,
	output sha_state_t state_o
);

	sched_win_t win         [NUM_ROUNDS];
	word_t      sched_word  [NUM_ROUNDS];
	sha_state_t round_state [NUM_ROUNDS + 1];

	// Message words then the fixed padding, W[0] in the top bits
	assign win[0] = {block_i, PAD_WORDS};

	assign round_state[0] = H_INIT;

	for (genvar t = 0; t < NUM_ROUNDS; t++) begin : g_stage
		// Stage t is one strobe ahead of round t
		if (t < NUM_ROUNDS - 1) begin : g_sched
			sha256_sched_stage i_sched (
				.CLK       (CLK),
				.RST       (RST),
				.advance_i (advance_i),
				.win_i     (win[t]),
				.win_o     (win[t + 1]),
				.word_o    (sched_word[t])
			);
		end else begin : g_sched_last
			// Nothing consumes the window after the last stage
			sha256_sched_stage i_sched (
				.CLK       (CLK),
				.RST       (RST),
				.advance_i (advance_i),
				.win_i     (win[t]),
				.win_o     (),
				.word_o    (sched_word[t])
			);
		end

		sha256_comp_round i_round (
			.CLK       (CLK),
			.RST       (RST),
			.advance_i (advance_i),
			.k_i       (ROUND_K[t]),
			.w_i       (sched_word[t]),
			.state_i   (round_state[t]),
			.state_o   (round_state[t + 1])
		);
	end

	assign state_o = round_state[NUM_ROUNDS];

endmodule

/* src/sha256_sched_stage.sv */
// SHA-256 message schedule stage
`timescale 1ns/1ps

module sha256_sched_stage import sha256_pkg::*; (
	input  logic       CLK,
	input  logic       RST,
	input  logic       advance_i,
	input  sched_win_t win_i,
	output sched_win_t win_o,
	output word_t      word_o
);

	sched_win_t win_q;
	word_t      next_word;

	// Holds W[t] .. W[t+15] for the block in this stage
	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			win_q <= '0;
		end else if (advance_i) begin
			win_q <= win_i;
		end
	end

	// W[t+16] = ssig1(W[t+14]) + W[t+9] + ssig0(W[t+1]) + W[t]
	assign next_word = ssig1(win_q[14]) + win_q[9] + ssig0(win_q[1]) + win_q[0];

	// Oldest word drops out, next stage sees W[t+1] .. W[t+16]
	assign win_o = {win_q[1:15], next_word};

	// Schedule word for the round fed by this stage
	assign word_o = win_q[0];

endmodule

/* vlog.f */
+incdir+bench
src/sha256_pkg.sv
src/sha256_sched_stage.sv
src/sha256_comp_round.sv
src/sha256_round_pipe.sv
src/sha256_digest_out.sv
src/sha256_block_hasher.sv
bench/tb_clock.sv
bench/sha256_tb.sv
